//--- clkgen_pkg.sv
package clkgen_pkg;

  // bus widths
  localparam int UP_AW = 14;
  localparam int UP_DW = 32;
  localparam int DRP_AW = 12;
  localparam int DRP_DW = 16;

  localparam logic [UP_DW-1:0] PCORE_VERSION = 32'h0005_0063;

  // register map, word addresses
  localparam logic [UP_AW-1:0] REG_VERSION    = 14'h000;
  localparam logic [UP_AW-1:0] REG_ID         = 14'h001;
  localparam logic [UP_AW-1:0] REG_SCRATCH    = 14'h002;
  localparam logic [UP_AW-1:0] REG_RSTN       = 14'h010;
  localparam logic [UP_AW-1:0] REG_STATUS     = 14'h017;
  localparam logic [UP_AW-1:0] REG_DRP_CNTRL  = 14'h01c;
  localparam logic [UP_AW-1:0] REG_DRP_STATUS = 14'h01d;

  // drp addresses of the divisor words
  localparam logic [DRP_AW-1:0] DRP_CLK0_DIV = 12'h008;
  localparam logic [DRP_AW-1:0] DRP_CLK1_DIV = 12'h00a;

  // divisor limits
  localparam logic [DRP_DW-1:0] DIV_RESET = 16'd6;
  localparam logic [DRP_DW-1:0] DIV_MIN   = 16'd2;

  // timing, in s_axi_aclk cycles
  localparam int DRP_LATENCY = 2;
  localparam int LOCK_CYCLES = 64;

endpackage

//--- up_if.sv
interface up_if;

  logic                          wreq;
  logic [clkgen_pkg::UP_AW-1:0]  waddr;
  logic [clkgen_pkg::UP_DW-1:0]  wdata;
  logic                          wack;
  logic                          rreq;
  logic [clkgen_pkg::UP_AW-1:0]  raddr;
  logic [clkgen_pkg::UP_DW-1:0]  rdata;
  logic                          rack;

  // one request in flight, ack follows one cycle later
  modport bridge (
    output wreq, waddr, wdata, rreq, raddr,
    input  wack, rdata, rack
  );

  modport regs (
    input  wreq, waddr, wdata, rreq, raddr,
    output wack, rdata, rack
  );

endinterface

//--- drp_if.sv
interface drp_if;

  logic                          sel;
  logic                          wr;
  logic [clkgen_pkg::DRP_AW-1:0] addr;
  logic [clkgen_pkg::DRP_DW-1:0] wdata;
  logic [clkgen_pkg::DRP_DW-1:0] rdata;
  logic                          ready;
  // level, not a pulse
  logic                          locked;

  modport master (
    output sel, wr, addr, wdata,
    input  rdata, ready, locked
  );

  modport slave (
    input  sel, wr, addr, wdata,
    output rdata, ready, locked
  );

endinterface

//--- clk_div_out.sv
module clk_div_out (
  input  logic                          s_axi_aclk,
  input  logic                          rst_n,
  input  logic                          div_rst,
  input  logic                          locked,
  input  logic [clkgen_pkg::DRP_DW-1:0] div,
  output logic                          clk_out
);

  logic [clkgen_pkg::DRP_DW-1:0] div_c;
  logic [clkgen_pkg::DRP_DW:0]   div_p1;
  logic [clkgen_pkg::DRP_DW-1:0] high_len;
  logic [clkgen_pkg::DRP_DW-1:0] cnt;

  // clamp, then high phase is half the period rounded up
  assign div_c    = (div < clkgen_pkg::DIV_MIN) ? clkgen_pkg::DIV_MIN : div;
  assign div_p1   = {1'b0, div_c} + 1'b1;
  assign high_len = div_p1[clkgen_pkg::DRP_DW:1];

  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n || div_rst || !locked) begin
      cnt     <= '0;
      clk_out <= 1'b0;
    end else begin
      clk_out <= (cnt < high_len);
      if (cnt >= div_c - 1'b1) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

//--- clk_div_drp.sv
module clk_div_drp (
  input  logic                          s_axi_aclk,
  input  logic                          rst_n,
  input  logic                          div_rst,
  drp_if.slave                          drp,
  output logic [clkgen_pkg::DRP_DW-1:0] clk0_div,
  output logic [clkgen_pkg::DRP_DW-1:0] clk1_div
);

  localparam int LAT_W  = $clog2(clkgen_pkg::DRP_LATENCY + 1);
  localparam int LOCK_W = $clog2(clkgen_pkg::LOCK_CYCLES);

  logic                          lat_busy;
  logic [LAT_W-1:0]              lat_cnt;
  logic                          lat_done;
  logic [clkgen_pkg::DRP_AW-1:0] addr_q;
  logic [LOCK_W-1:0]             lock_cnt;
  logic                          div_wr;

  assign lat_done = lat_busy && (lat_cnt == LAT_W'(clkgen_pkg::DRP_LATENCY - 1));
  assign div_wr   = drp.sel && drp.wr &&
                    ((drp.addr == clkgen_pkg::DRP_CLK0_DIV) ||
                     (drp.addr == clkgen_pkg::DRP_CLK1_DIV));

  // divisor store and access latency
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      clk0_div  <= clkgen_pkg::DIV_RESET;
      clk1_div  <= clkgen_pkg::DIV_RESET;
      lat_busy  <= 1'b0;
      lat_cnt   <= '0;
      drp.ready <= 1'b0;
    end else begin
      drp.ready <= lat_done;
      if (drp.sel) begin
        lat_busy <= 1'b1;
        lat_cnt  <= LAT_W'(1);
        if (drp.wr && (drp.addr == clkgen_pkg::DRP_CLK0_DIV)) begin
          clk0_div <= drp.wdata;
        end
        if (drp.wr && (drp.addr == clkgen_pkg::DRP_CLK1_DIV)) begin
          clk1_div <= drp.wdata;
        end
      end else if (lat_done) begin
        lat_busy <= 1'b0;
      end else if (lat_busy) begin
        lat_cnt <= lat_cnt + LAT_W'(1);
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (drp.sel) begin
      addr_q <= drp.addr;
    end
    if (lat_done) begin
      case (addr_q)
        clkgen_pkg::DRP_CLK0_DIV: drp.rdata <= clk0_div;
        clkgen_pkg::DRP_CLK1_DIV: drp.rdata <= clk1_div;
        default:                  drp.rdata <= '0;
      endcase
    end
  end

  // lock model, relocks after reset release or a new divisor
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n || div_rst || div_wr) begin
      lock_cnt   <= '0;
      drp.locked <= 1'b0;
    end else if (!drp.locked) begin
      if (lock_cnt == LOCK_W'(clkgen_pkg::LOCK_CYCLES - 1)) begin
        drp.locked <= 1'b1;
      end else begin
        lock_cnt <= lock_cnt + LOCK_W'(1);
      end
    end
  end

endmodule

//--- up_axi.sv
module up_axi (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        awvalid,
  input  logic [15:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [31:0] wdata,
  input  logic [ 3:0] wstrb,
  output logic        wready,
  output logic        bvalid,
  output logic [ 1:0] bresp,
  input  logic        bready,
  input  logic        arvalid,
  input  logic [15:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [ 1:0] rresp,
  input  logic        rready,
  up_if.bridge        up
);

  logic wr_pend;
  logic rd_pend;
  logic wr_accept;
  logic rd_accept;

  // wstrb is not decoded, writes always store the full word
  assign wr_accept = awvalid && wvalid && !wr_pend;
  assign rd_accept = arvalid && !rd_pend;

  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // write channel
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      wr_pend <= 1'b0;
      up.wreq <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= wr_accept;
      wready  <= wr_accept;
      up.wreq <= awready;
      if (wr_accept) begin
        wr_pend <= 1'b1;
      end
      if (up.wack) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid  <= 1'b0;
        wr_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (wr_accept) begin
      up.waddr <= awaddr[15:2];
      up.wdata <= wdata;
    end
  end

  // read channel
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rd_pend <= 1'b0;
      up.rreq <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= rd_accept;
      up.rreq <= arready;
      if (rd_accept) begin
        rd_pend <= 1'b1;
      end
      if (up.rack) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge s_axi_aclk) begin
    if (rd_accept) begin
      up.raddr <= araddr[15:2];
    end
    if (up.rack) begin
      rdata <= up.rdata;
    end
  end

endmodule

//--- up_clkgen.sv
module up_clkgen #(
  parameter logic [31:0] ID = 32'h0
) (
  input  logic  s_axi_aclk,
  input  logic  rst_n,
  up_if.regs    up,
  drp_if.master drp,
  output logic  div_rst
);

  logic [clkgen_pkg::UP_DW-1:0]  scratch;
  logic                          drp_busy;
  logic [clkgen_pkg::DRP_DW-1:0] drp_rdata_last;
  logic                          drp_launch;

  // a new command while busy is dropped
  assign drp_launch = up.wreq && (up.waddr == clkgen_pkg::REG_DRP_CNTRL) && !drp_busy;

  // register writes and drp sequencing
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      up.wack        <= 1'b0;
      scratch        <= '0;
      div_rst        <= 1'b1;
      drp.sel        <= 1'b0;
      drp_busy       <= 1'b0;
      drp_rdata_last <= '0;
    end else begin
      up.wack <= up.wreq;
      drp.sel <= drp_launch;
      if (up.wreq) begin
        case (up.waddr)
          clkgen_pkg::REG_SCRATCH: scratch <= up.wdata;
          clkgen_pkg::REG_RSTN:    div_rst <= ~up.wdata[0];
          default: ;
        endcase
      end
      if (drp_launch) begin
        drp_busy <= 1'b1;
      end else if (drp.ready) begin
        drp_busy <= 1'b0;
        if (!drp.wr) begin
          drp_rdata_last <= drp.rdata;
        end
      end
    end
  end

  // command fields, held until the next launch
  always_ff @(posedge s_axi_aclk) begin
    if (drp_launch) begin
      drp.wr    <= ~up.wdata[28];
      drp.addr  <= up.wdata[27:16];
      drp.wdata <= up.wdata[15:0];
    end
  end

  // register reads
  always_ff @(posedge s_axi_aclk) begin
    if (!rst_n) begin
      up.rack  <= 1'b0;
      up.rdata <= '0;
    end else begin
      up.rack  <= up.rreq;
      up.rdata <= '0;
      if (up.rreq) begin
        case (up.raddr)
          clkgen_pkg::REG_VERSION:    up.rdata <= clkgen_pkg::PCORE_VERSION;
          clkgen_pkg::REG_ID:         up.rdata <= ID;
          clkgen_pkg::REG_SCRATCH:    up.rdata <= scratch;
          clkgen_pkg::REG_RSTN:       up.rdata <= {31'd0, ~div_rst};
          clkgen_pkg::REG_STATUS:     up.rdata <= {31'd0, drp.locked};
          clkgen_pkg::REG_DRP_STATUS: up.rdata <= {15'd0, drp_busy, drp_rdata_last};
          default:                    up.rdata <= '0;
        endcase
      end
    end
  end

endmodule

//--- axi_clkgen.sv
module axi_clkgen #(
  parameter logic [31:0] ID = 32'h0
) (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        s_axi_awvalid,
  input  logic [15:0] s_axi_awaddr,
  output logic        s_axi_awready,
  input  logic        s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [ 3:0] s_axi_wstrb,
  output logic        s_axi_wready,
  output logic        s_axi_bvalid,
  output logic [ 1:0] s_axi_bresp,
  input  logic        s_axi_bready,
  input  logic        s_axi_arvalid,
  input  logic [15:0] s_axi_araddr,
  output logic        s_axi_arready,
  output logic        s_axi_rvalid,
  output logic [31:0] s_axi_rdata,
  output logic [ 1:0] s_axi_rresp,
  input  logic        s_axi_rready,
  output logic        clk_0,
  output logic        clk_1
);

  logic                          div_rst;
  logic [clkgen_pkg::DRP_DW-1:0] clk0_div;
  logic [clkgen_pkg::DRP_DW-1:0] clk1_div;

  up_if  up_bus ();
  drp_if drp_bus ();

  up_axi i_up_axi (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .awvalid    (s_axi_awvalid),
    .awaddr     (s_axi_awaddr),
    .awready    (s_axi_awready),
    .wvalid     (s_axi_wvalid),
    .wdata      (s_axi_wdata),
    .wstrb      (s_axi_wstrb),
    .wready     (s_axi_wready),
    .bvalid     (s_axi_bvalid),
    .bresp      (s_axi_bresp),
    .bready     (s_axi_bready),
    .arvalid    (s_axi_arvalid),
    .araddr     (s_axi_araddr),
    .arready    (s_axi_arready),
    .rvalid     (s_axi_rvalid),
    .rdata      (s_axi_rdata),
    .rresp      (s_axi_rresp),
    .rready     (s_axi_rready),
    .up         (up_bus)
  );

  up_clkgen #(
    .ID (ID)
  ) i_up_clkgen (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .up         (up_bus),
    .drp        (drp_bus),
    .div_rst    (div_rst)
  );

  clk_div_drp i_clk_div_drp (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .div_rst    (div_rst),
    .drp        (drp_bus),
    .clk0_div   (clk0_div),
    .clk1_div   (clk1_div)
  );

  // one divider per output clock
  clk_div_out i_clk_div_0 (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .div_rst    (div_rst),
    .locked     (drp_bus.locked),
    .div        (clk0_div),
    .clk_out    (clk_0)
  );

  clk_div_out i_clk_div_1 (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .div_rst    (div_rst),
    .locked     (drp_bus.locked),
    .div        (clk1_div),
    .clk_out    (clk_1)
  );

endmodule

//--- tb_axi_clkgen.sv
module tb_axi_clkgen;
  timeunit 1ns;
  timeprecision 100ps;

  typedef enum {OP_WRITE, OP_READ, OP_POLL, OP_DRP_WR, OP_DRP_RD, OP_MEAS0, OP_MEAS1, OP_IDLE0} op_t;

  localparam logic [31:0] DUT_ID = 32'h0000_1234;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        awvalid, wvalid, bready, arvalid, rready;
  logic [15:0] awaddr, araddr;
  logic [31:0] wdata;
  logic [ 3:0] wstrb;
  logic        awready, wready, bvalid, arready, rvalid;
  logic [ 1:0] bresp, rresp;
  logic [31:0] rdata;
  logic        clk_0, clk_1;

  // stimulus table
  string       t_name [0:19];
  op_t         t_op   [0:19];
  logic [15:0] t_addr [0:19];
  logic [31:0] t_data [0:19];
  logic [31:0] t_exp  [0:19];
  int          n_tests = 0;
  bit          table_ready = 1'b0;
  int          cycle_cnt = 0;
  integer      seed = 32'h949b;

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  axi_clkgen #(.ID(DUT_ID)) uut (
    .s_axi_aclk(clk), .rst_n(rst_n),
    .s_axi_awvalid(awvalid), .s_axi_awaddr(awaddr), .s_axi_awready(awready),
    .s_axi_wvalid(wvalid), .s_axi_wdata(wdata), .s_axi_wstrb(wstrb), .s_axi_wready(wready),
    .s_axi_bvalid(bvalid), .s_axi_bresp(bresp), .s_axi_bready(bready),
    .s_axi_arvalid(arvalid), .s_axi_araddr(araddr), .s_axi_arready(arready),
    .s_axi_rvalid(rvalid), .s_axi_rdata(rdata), .s_axi_rresp(rresp), .s_axi_rready(rready),
    .clk_0(clk_0), .clk_1(clk_1)
  );

  function automatic logic [15:0] byte_addr(input logic [13:0] word);
    return {word, 2'b00};
  endfunction

  function automatic logic clk_of(input bit which);
    return which ? clk_1 : clk_0;
  endfunction

  task automatic add_test(input string name, input op_t op, input logic [15:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    t_name[n_tests] = name;
    t_op[n_tests]   = op;
    t_addr[n_tests] = addr;
    t_data[n_tests] = data;
    t_exp[n_tests]  = exp;
    n_tests = n_tests + 1;
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           output logic [1:0] resp, output bit hung, output string note);
    int cnt;
    cnt = 0;
    hung = 1'b0;
    resp = 2'b00;
    note = "";
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    @(negedge clk);
    while (!(awready && wready) && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    // handshake happens on the next rising edge
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (cnt >= 32) begin
      hung = 1'b1;
      note = $sformatf("awready never came for the write to %h", addr);
      return;
    end
    cnt = 0;
    while (!bvalid && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    if (!bvalid) begin
      hung = 1'b1;
      note = $sformatf("bvalid never came for the write to %h", addr);
      return;
    end
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data,
                          output logic [1:0] resp, output bit hung, output string note);
    int cnt;
    cnt = 0;
    data = '0;
    hung = 1'b0;
    resp = 2'b00;
    note = "";
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    @(negedge clk);
    while (!arready && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    if (cnt >= 32) begin
      hung = 1'b1;
      note = $sformatf("arready never came for the read of %h", addr);
      return;
    end
    cnt = 0;
    while (!rvalid && cnt < 32) begin
      @(negedge clk);
      cnt++;
    end
    if (!rvalid) begin
      hung = 1'b1;
      note = $sformatf("rvalid never came for the read of %h", addr);
      return;
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
  endtask

  // reads until the masked value matches or the cycle limit runs out
  task automatic poll_reg(input logic [15:0] addr, input logic [31:0] mask,
                          input logic [31:0] exp, input int lim, output logic [31:0] actual,
                          output logic [1:0] resp, output bit hung, output string note);
    int          start;
    logic [31:0] value;
    bit          done;
    start  = cycle_cnt;
    done   = 1'b0;
    actual = '0;
    while (!done) begin
      axi_read(addr, value, resp, hung, note);
      actual = value & mask;
      if (hung || resp != 2'b00 || actual == exp || cycle_cnt - start > lim) begin
        done = 1'b1;
      end
    end
  endtask

  task automatic drp_access(input bit write, input logic [11:0] addr, input logic [15:0] data,
                            output logic [31:0] actual, output logic [1:0] resp,
                            output bit hung, output string note);
    logic [31:0] busy;
    logic [31:0] status;
    actual = '0;
    busy   = '0;
    axi_write(byte_addr(clkgen_pkg::REG_DRP_CNTRL), {3'b000, !write, addr, data},
              resp, hung, note);
    if (!hung && resp == 2'b00) begin
      poll_reg(byte_addr(clkgen_pkg::REG_DRP_STATUS), 32'h0001_0000, 32'h0, 32,
               busy, resp, hung, note);
    end
    if (!hung && resp == 2'b00 && busy != 32'h0) begin
      hung = 1'b1;
      note = "the DRP busy bit never cleared";
    end
    if (!write && !hung && resp == 2'b00) begin
      axi_read(byte_addr(clkgen_pkg::REG_DRP_STATUS), status, resp, hung, note);
      actual = {16'd0, status[15:0]};
    end
  endtask

  // counts s_axi_aclk cycles between two rising edges of the chosen output
  task automatic measure_period(input bit which, input int lim, output int cycles,
                                output bit hung);
    int   cnt;
    int   rises;
    logic prev;
    logic cur;
    cnt    = 0;
    rises  = 0;
    cycles = 0;
    @(negedge clk);
    prev = clk_of(which);
    while (rises < 2 && cnt < lim) begin
      @(negedge clk);
      cnt++;
      cur = clk_of(which);
      if (rises == 1) begin
        cycles++;
      end
      if (!prev && cur) begin
        rises++;
      end
      prev = cur;
    end
    hung = (rises < 2);
  endtask

  initial begin
    int div_total;
    int i;
    wait (table_ready);
    div_total = 0;
    for (i = 0; i < n_tests; i++) begin
      if (t_op[i] == OP_MEAS0 || t_op[i] == OP_MEAS1) begin
        div_total = div_total + int'(t_data[i]);
      end
    end
    repeat (n_tests * 200 + div_total * 4) @(posedge clk);
    $display("watchdog expired, the test sequence did not finish");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    logic [31:0] scratch_val;
    logic [31:0] actual;
    logic [ 1:0] resp;
    bit          hung;
    string       note;
    int          cycles;
    int          n_pass;
    int          n_fail;
    int          i;
    n_pass  = 0;
    n_fail  = 0;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    scratch_val = $random(seed);

    add_test("version", OP_READ, byte_addr(clkgen_pkg::REG_VERSION), 0, clkgen_pkg::PCORE_VERSION);
    add_test("id", OP_READ, byte_addr(clkgen_pkg::REG_ID), 0, DUT_ID);
    add_test("unmapped", OP_READ, byte_addr(14'h0ff), 0, 32'h0);
    add_test("scratch write", OP_WRITE, byte_addr(clkgen_pkg::REG_SCRATCH), scratch_val, 32'h0);
    add_test("scratch read", OP_READ, byte_addr(clkgen_pkg::REG_SCRATCH), 0, scratch_val);
    add_test("status after reset", OP_READ, byte_addr(clkgen_pkg::REG_STATUS), 0, 32'h0);
    add_test("clk_0 held low", OP_IDLE0, 16'h0, 32'd32, 32'h0);
    add_test("release divider", OP_WRITE, byte_addr(clkgen_pkg::REG_RSTN), 32'h1, 32'h0);
    add_test("first lock", OP_POLL, byte_addr(clkgen_pkg::REG_STATUS), 32'h1, 32'h1);
    add_test("drp write clk0", OP_DRP_WR, {4'd0, clkgen_pkg::DRP_CLK0_DIV}, 32'd10, 32'h0);
    add_test("drp read clk0", OP_DRP_RD, {4'd0, clkgen_pkg::DRP_CLK0_DIV}, 0, 32'd10);
    add_test("drp read unused", OP_DRP_RD, 16'h00ff, 0, 32'h0);
    add_test("relock clk0", OP_POLL, byte_addr(clkgen_pkg::REG_STATUS), 32'h1, 32'h1);
    add_test("clk_0 period", OP_MEAS0, 16'h0, 32'd10, 32'd10 * 8);
    add_test("clk_1 period", OP_MEAS1, 16'h0, 32'd6, 32'd6 * 8);
    add_test("drp write clk1", OP_DRP_WR, {4'd0, clkgen_pkg::DRP_CLK1_DIV}, 32'd1, 32'h0);
    add_test("relock clk1", OP_POLL, byte_addr(clkgen_pkg::REG_STATUS), 32'h1, 32'h1);
    add_test("clk_1 clamped", OP_MEAS1, 16'h0, 32'd2, 32'd2 * 8);
    table_ready = 1'b1;

    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    for (i = 0; i < n_tests; i++) begin
      actual = '0;
      resp   = 2'b00;
      hung   = 1'b0;
      note   = "";
      case (t_op[i])
        OP_WRITE: begin
          axi_write(t_addr[i], t_data[i], resp, hung, note);
        end
        OP_READ: axi_read(t_addr[i], actual, resp, hung, note);
        OP_POLL: begin
          poll_reg(t_addr[i], t_data[i], t_exp[i], clkgen_pkg::LOCK_CYCLES + 64,
                   actual, resp, hung, note);
        end
        OP_DRP_WR: drp_access(1'b1, t_addr[i][11:0], t_data[i][15:0], actual, resp, hung, note);
        OP_DRP_RD: drp_access(1'b0, t_addr[i][11:0], 16'h0, actual, resp, hung, note);
        OP_MEAS0, OP_MEAS1: begin
          measure_period(t_op[i] == OP_MEAS1, 4 * int'(t_data[i]) + 8, cycles, hung);
          actual = cycles * 8;
          if (hung) begin
            note = "the output clock did not toggle";
          end
        end
        OP_IDLE0: begin
          repeat (t_data[i]) begin
            @(negedge clk);
            if (clk_0) begin
              actual = 32'h1;
            end
          end
        end
        default: begin
          hung = 1'b1;
          note = "unknown table operation";
        end
      endcase
      if (hung) begin
        $display("%s: gave up, %s", t_name[i], note);
        n_fail++;
      end else if (resp != 2'b00) begin
        $display("Error %s: response expected 0 actual %0d", t_name[i], resp);
        n_fail++;
      end else if (actual !== t_exp[i]) begin
        $display("Error %s: expected %h actual %h", t_name[i], t_exp[i], actual);
        n_fail++;
      end else begin
        $display("ok    %s (%h)", t_name[i], actual);
        n_pass++;
      end
    end

    $display("tests passed %0d failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- sim.f
clkgen_pkg.sv
up_if.sv
drp_if.sv
clk_div_out.sv
clk_div_drp.sv
up_axi.sv
up_clkgen.sv
axi_clkgen.sv
tb_axi_clkgen.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_clkgen
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/100ps -j 0

SRCS := $(filter %.sv,$(shell cat sim.f))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): sim.f $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f sim.f

run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
